// ==== source/idStage_config.svh ====
`ifndef IDSTAGE_CONFIG_SVH
`define IDSTAGE_CONFIG_SVH

// Datapath and register file sizes
`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
`define NUM_REGS        32

// Width of the ALU operation code handed to EX
`define ALU_OP_WIDTH    4

// Link register written by call
`define CALL_LINK_REG   15

`endif

// ==== source/idStagePkg.sv ====
`include "idStage_config.svh"

package idStagePkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [`ALU_OP_WIDTH-1:0]   aluOp_t;
    typedef logic [1:0]                 memSize_t;
    typedef logic [1:0]                 fwdSel_t;

    localparam memSize_t SIZE_BYTE = 2'd0;
    localparam memSize_t SIZE_HALF = 2'd1;
    localparam memSize_t SIZE_WORD = 2'd2;

    localparam fwdSel_t FWD_RF  = 2'd0;  // Register file when no stage matches
    localparam fwdSel_t FWD_EX  = 2'd1;
    localparam fwdSel_t FWD_MEM = 2'd2;
    localparam fwdSel_t FWD_WB  = 2'd3;

    // Sixteen control bits, msb first
    typedef struct packed {
        logic     jmpl;
        logic     memWrite;
        aluOp_t   aluOp;
        logic     signExtend;
        logic     load;
        logic     rfEnable;
        memSize_t size;
        logic     modifyCC;
        logic     call;
        logic     branch;
        logic     annul;
        logic     memEnable;
    } ctrl_t;

    // Result of one later stage as seen from ID
    typedef struct packed {
        logic     rfEnable;
        regAddr_t dest;
        word_t    value;
    } stageFwd_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    operandA;
        word_t    operandB;
        word_t    storeData;
        regAddr_t dest;
    } idEx_t;

endpackage

// ==== source/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder import idStagePkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    logic [1:0] op;
    logic [5:0] op3;

    assign op  = instr[31:30];
    assign op3 = instr[24:19];

    always_comb
    begin
        ctrl = '0;
        case (op)
            2'd1:
            begin
                ctrl.rfEnable = 1'b1;  // Return address goes to r15
                ctrl.call     = 1'b1;
            end
            2'd0:
            begin
                if (instr == '0)
                begin
                    ctrl = '0;  // Nop
                end
                else if (instr[24:22] == 3'd4)
                begin
                    ctrl.aluOp    = 4'd14;  // SETHI passes operand B
                    ctrl.rfEnable = 1'b1;
                end
                else
                begin
                    ctrl.branch = 1'b1;
                    ctrl.annul  = instr[29];
                end
            end
            2'd2:
            begin
                ctrl.rfEnable = 1'b1;
                if (op3 == 6'd56)
                begin
                    ctrl.jmpl = 1'b1;  // Target address from the ALU
                end
                else
                begin
                    ctrl.modifyCC = instr[23];  // The cc variants
                    case (op3[3:0])
                        4'd0:    ctrl.aluOp = 4'd0;   // Add
                        4'd8:    ctrl.aluOp = 4'd1;   // Add with carry
                        4'd4:    ctrl.aluOp = 4'd2;   // Sub
                        4'd12:   ctrl.aluOp = 4'd3;   // Sub with carry
                        4'd1:    ctrl.aluOp = 4'd4;   // And
                        4'd2:    ctrl.aluOp = 4'd5;   // Or
                        4'd3:    ctrl.aluOp = 4'd6;   // Xor
                        4'd5:    ctrl.aluOp = op3[5] ? 4'd10 : 4'd8;  // Sll or andn
                        4'd6:    ctrl.aluOp = op3[5] ? 4'd11 : 4'd9;  // Srl or orn
                        4'd7:    ctrl.aluOp = op3[5] ? 4'd12 : 4'd7;  // Sra or xnor
                        default: ctrl.aluOp = 4'd0;
                    endcase
                end
            end
            default:
            begin
                ctrl.memEnable = 1'b1;
                case (op3)
                    6'd9:
                    begin
                        ctrl.load       = 1'b1;  // ldsb
                        ctrl.rfEnable   = 1'b1;
                        ctrl.signExtend = 1'b1;
                        ctrl.size       = SIZE_BYTE;
                    end
                    6'd10:
                    begin
                        ctrl.load       = 1'b1;  // ldsh
                        ctrl.rfEnable   = 1'b1;
                        ctrl.signExtend = 1'b1;
                        ctrl.size       = SIZE_HALF;
                    end
                    6'd0:
                    begin
                        ctrl.load     = 1'b1;  // ld
                        ctrl.rfEnable = 1'b1;
                        ctrl.size     = SIZE_WORD;
                    end
                    6'd1:
                    begin
                        ctrl.load     = 1'b1;  // ldub
                        ctrl.rfEnable = 1'b1;
                        ctrl.size     = SIZE_BYTE;
                    end
                    6'd2:
                    begin
                        ctrl.load     = 1'b1;  // lduh
                        ctrl.rfEnable = 1'b1;
                        ctrl.size     = SIZE_HALF;
                    end
                    6'd5:
                    begin
                        ctrl.memWrite = 1'b1;  // stb
                        ctrl.size     = SIZE_BYTE;
                    end
                    6'd6:
                    begin
                        ctrl.memWrite = 1'b1;  // sth
                        ctrl.size     = SIZE_HALF;
                    end
                    6'd4:
                    begin
                        ctrl.memWrite = 1'b1;  // st
                        ctrl.size     = SIZE_WORD;
                    end
                    default:
                    begin
                        ctrl.memEnable = 1'b1;  // Unknown access type
                    end
                endcase
            end
        endcase
    end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module registerFile import idStagePkg::*;
(
    input  logic     Clk,
    input  logic     wrEnable,
    input  regAddr_t wrAddr,
    input  word_t    wrData,
    input  regAddr_t rdAddrA,
    input  regAddr_t rdAddrB,
    input  regAddr_t rdAddrC,
    output word_t    rdDataA,
    output word_t    rdDataB,
    output word_t    rdDataC
);

    word_t regs [`NUM_REGS];

    // Entry 0 is never written
    always_ff @(posedge Clk)
    begin
        if (wrEnable && (wrAddr != '0))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // r0 is wired to zero on every port
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];
    assign rdDataC = (rdAddrC == '0) ? '0 : regs[rdAddrC];

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import idStagePkg::*;
(
    input  regAddr_t  rs1,
    input  regAddr_t  rs2,
    input  regAddr_t  rdStore,
    input  logic      useRs2,
    input  stageFwd_t exStage,
    input  stageFwd_t memStage,
    input  stageFwd_t wbStage,
    input  logic      exLoad,
    output fwdSel_t   selA,
    output fwdSel_t   selB,
    output fwdSel_t   selStore,
    output logic      stall
);

    // Youngest matching stage wins
    function automatic fwdSel_t pickStage(
        input regAddr_t  src,
        input logic      srcUsed,
        input stageFwd_t ex,
        input stageFwd_t mem,
        input stageFwd_t wb
    );
        fwdSel_t sel;
        sel = FWD_RF;
        if (srcUsed && (src != '0))
        begin
            if (ex.rfEnable && (ex.dest == src))
                sel = FWD_EX;
            else if (mem.rfEnable && (mem.dest == src))
                sel = FWD_MEM;
            else if (wb.rfEnable && (wb.dest == src))
                sel = FWD_WB;
        end
        return sel;
    endfunction

    assign selA     = pickStage(rs1, 1'b1, exStage, memStage, wbStage);
    assign selB     = pickStage(rs2, useRs2, exStage, memStage, wbStage);
    assign selStore = pickStage(rdStore, 1'b1, exStage, memStage, wbStage);

    // Load result not ready until MEM
    assign stall = exLoad && (exStage.dest != '0) &&
                   ((exStage.dest == rs1) || (useRs2 && (exStage.dest == rs2)));

endmodule

// ==== source/operandSelect.sv ====
`timescale 1ns/1ps

module operandSelect import idStagePkg::*;
(
    input  fwdSel_t     selA,
    input  fwdSel_t     selB,
    input  fwdSel_t     selStore,
    input  word_t       rfA,
    input  word_t       rfB,
    input  word_t       rfStore,
    input  stageFwd_t   exStage,
    input  stageFwd_t   memStage,
    input  stageFwd_t   wbStage,
    input  logic [1:0]  immMode,
    input  logic [21:0] imm22,
    output word_t       operandA,
    output word_t       operandB,
    output word_t       storeData
);

    localparam int SIMM_PAD = $bits(word_t) - 13;

    word_t regB;

    function automatic word_t fwdMux(
        input fwdSel_t sel,
        input word_t   rfValue,
        input word_t   exValue,
        input word_t   memValue,
        input word_t   wbValue
    );
        case (sel)
            FWD_EX:  return exValue;
            FWD_MEM: return memValue;
            FWD_WB:  return wbValue;
            default: return rfValue;
        endcase
    endfunction

    assign operandA  = fwdMux(selA, rfA, exStage.value, memStage.value, wbStage.value);
    assign regB      = fwdMux(selB, rfB, exStage.value, memStage.value, wbStage.value);
    assign storeData = fwdMux(selStore, rfStore, exStage.value, memStage.value, wbStage.value);

    always_comb
    begin
        case (immMode)
            2'd1:    operandB = {{SIMM_PAD{imm22[12]}}, imm22[12:0]};  // simm13
            2'd2:    operandB = {imm22, 10'b0};  // SETHI constant
            default: operandB = regB;
        endcase
    end

endmodule

// ==== source/idStage.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module idStage import idStagePkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  word_t     instr,
    input  stageFwd_t exStage,
    input  stageFwd_t memStage,
    input  stageFwd_t wbStage,
    input  logic      exLoad,
    output idEx_t     idEx,
    output logic      stall
);

    regAddr_t    rs1;
    regAddr_t    rs2;
    regAddr_t    rd;
    regAddr_t    dest;
    logic [21:0] imm22;
    logic [1:0]  immMode;
    logic        useRs2;
    ctrl_t       ctrl;
    word_t       rfA;
    word_t       rfB;
    word_t       rfStore;
    fwdSel_t     selA;
    fwdSel_t     selB;
    fwdSel_t     selStore;
    word_t       operandA;
    word_t       operandB;
    word_t       storeData;

    assign rs1   = instr[18:14];
    assign rs2   = instr[4:0];
    assign rd    = instr[29:25];  // Also the store source
    assign imm22 = instr[21:0];

    always_comb
    begin
        if (ctrl.aluOp == 4'd14)
            immMode = 2'd2;
        else if (instr[31] && instr[13])
            immMode = 2'd1;  // i bit on format 3
        else
            immMode = 2'd0;
    end

    assign useRs2 = (immMode == 2'd0);
    assign dest   = ctrl.call ? regAddr_t'(`CALL_LINK_REG) : rd;

    controlDecoder u_controlDecoder (.instr(instr), .ctrl(ctrl));

    registerFile u_registerFile (
        .Clk(Clk), .wrEnable(wbStage.rfEnable), .wrAddr(wbStage.dest), .wrData(wbStage.value),
        .rdAddrA(rs1), .rdAddrB(rs2), .rdAddrC(rd),
        .rdDataA(rfA), .rdDataB(rfB), .rdDataC(rfStore)
    );

    hazardUnit u_hazardUnit (
        .rs1(rs1), .rs2(rs2), .rdStore(rd), .useRs2(useRs2),
        .exStage(exStage), .memStage(memStage), .wbStage(wbStage), .exLoad(exLoad),
        .selA(selA), .selB(selB), .selStore(selStore), .stall(stall)
    );

    operandSelect u_operandSelect (
        .selA(selA), .selB(selB), .selStore(selStore),
        .rfA(rfA), .rfB(rfB), .rfStore(rfStore),
        .exStage(exStage), .memStage(memStage), .wbStage(wbStage),
        .immMode(immMode), .imm22(imm22),
        .operandA(operandA), .operandB(operandB), .storeData(storeData)
    );

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            idEx <= '0;
        end
        else
        begin
            idEx.ctrl      <= stall ? '0 : ctrl;  // Bubble while held
            idEx.operandA  <= operandA;
            idEx.operandB  <= operandB;
            idEx.storeData <= storeData;
            idEx.dest      <= dest;
        end
    end

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen
(
    output logic Clk,
    output logic rstN
);

    localparam int RESET_CYCLES = 5;

    initial
    begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;  // 4 ns period
    end

    initial
    begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        rstN <= 1'b1;  // Released on an edge like the other inputs
    end

endmodule

// ==== test/idStageTb.sv ====
`timescale 1ns/1ps
`include "idStage_config.svh"

module idStageTb import idStagePkg::*;
();

    localparam int NUM_RANDOM = 200;
    localparam int NUM_FWD    = 200;
    localparam int NUM_LOADS  = 60;
    localparam int CYCLE_LIMIT = 10 + 2 * `NUM_REGS + NUM_RANDOM + NUM_FWD + NUM_LOADS + 100;

    logic        Clk;
    logic        rstN;
    word_t       instr;
    stageFwd_t   exStage;
    stageFwd_t   memStage;
    stageFwd_t   wbStage;
    logic        exLoad;
    idEx_t       idEx;
    logic        stall;
    word_t       modelRegs [`NUM_REGS];
    idEx_t       expIdEx;
    logic        expValid = 1'b0;
    logic [15:0] lfsrState = 16'd76;
    int          checkCount = 0;
    int          errCount = 0;
    int          testErrStart = 0;
    int          testNum = 0;
    int          cycleCount = 0;

    clockGen u_clockGen (.Clk(Clk), .rstN(rstN));

    idStage u_idStage (
        .Clk(Clk), .rstN(rstN), .instr(instr), .exStage(exStage), .memStage(memStage),
        .wbStage(wbStage), .exLoad(exLoad), .idEx(idEx), .stall(stall)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic randomBits(input int n, output word_t v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    function automatic word_t formatInstr(input logic [1:0] op, input regAddr_t rd,
                                          input logic [5:0] op3, input regAddr_t rs1,
                                          input logic i, input logic [12:0] low);
        return {op, rd, op3, rs1, i, low};
    endfunction

    function automatic stageFwd_t makeStage(input logic en, input regAddr_t dest, input word_t v);
        stageFwd_t s;
        s.rfEnable = en;
        s.dest     = dest;
        s.value    = v;
        return s;
    endfunction

    // 2 is SETHI, 1 is simm13 on formats 2 and 3, 0 is a register operand
    function automatic logic [1:0] immForm(input word_t ins);
        if (ins[31:30] == 2'b00 && ins[24:22] == 3'b100)
            return 2'd2;
        return (ins[31:30] >= 2'b10 && ins[13]) ? 2'd1 : 2'd0;
    endfunction

    function automatic ctrl_t refCtrl(input word_t ins);
        ctrl_t      c;
        logic [5:0] op3;
        c   = '0;
        op3 = ins[24:19];
        case (ins[31:30])
            2'b01:
            begin
                c.call     = 1'b1;
                c.rfEnable = 1'b1;
            end
            2'b00:
            begin
                if (immForm(ins) == 2'd2)
                begin
                    c.aluOp    = 4'd14;
                    c.rfEnable = 1'b1;
                end
                else if (ins != '0)
                begin
                    c.branch = 1'b1;
                    c.annul  = ins[29];
                end
            end
            2'b10:
            begin
                c.rfEnable = 1'b1;
                c.jmpl     = (op3 == 6'd56);
                c.modifyCC = (op3 != 6'd56) && ins[23];
                case (op3[3:0])
                    4'd8:    c.aluOp = 4'd1;
                    4'd4:    c.aluOp = 4'd2;
                    4'd12:   c.aluOp = 4'd3;
                    4'd1:    c.aluOp = 4'd4;
                    4'd2:    c.aluOp = 4'd5;
                    4'd3:    c.aluOp = 4'd6;
                    4'd5:    c.aluOp = op3[5] ? 4'd10 : 4'd8;
                    4'd6:    c.aluOp = op3[5] ? 4'd11 : 4'd9;
                    4'd7:    c.aluOp = op3[5] ? 4'd12 : 4'd7;
                    default: c.aluOp = 4'd0;
                endcase
                if (op3 == 6'd56)
                    c.aluOp = 4'd0;  // jmpl adds
            end
            default:
            begin
                c.memEnable  = 1'b1;
                c.load       = (op3 == 6'd0) || (op3 == 6'd1) || (op3 == 6'd2) ||
                               (op3 == 6'd9) || (op3 == 6'd10);
                c.rfEnable   = c.load;
                c.memWrite   = (op3 == 6'd4) || (op3 == 6'd5) || (op3 == 6'd6);
                c.signExtend = (op3 == 6'd9) || (op3 == 6'd10);
                if ((op3 == 6'd2) || (op3 == 6'd6) || (op3 == 6'd10))
                    c.size = SIZE_HALF;
                else if ((op3 == 6'd0) || (op3 == 6'd4))
                    c.size = SIZE_WORD;
            end
        endcase
        return c;
    endfunction

    function automatic word_t refForward(input regAddr_t r, input stageFwd_t ex,
                                         input stageFwd_t mem, input stageFwd_t wb);
        if (r == 0)
            return '0;
        if (ex.rfEnable && ex.dest == r)
            return ex.value;
        if (mem.rfEnable && mem.dest == r)
            return mem.value;
        if (wb.rfEnable && wb.dest == r)
            return wb.value;
        return modelRegs[r];
    endfunction

    function automatic logic refStall(input word_t ins, input stageFwd_t ex, input logic load);
        logic rs2Used;
        rs2Used = (immForm(ins) == 2'd0);
        return load && (ex.dest != 0) &&
               (ex.dest == ins[18:14] || (rs2Used && ex.dest == ins[4:0]));
    endfunction

    function automatic idEx_t refIdEx(input word_t ins, input stageFwd_t ex,
                                      input stageFwd_t mem, input stageFwd_t wb, input logic load);
        idEx_t e;
        ctrl_t c;
        c          = refCtrl(ins);
        e.ctrl     = refStall(ins, ex, load) ? '0 : c;
        e.operandA = refForward(ins[18:14], ex, mem, wb);
        case (immForm(ins))
            2'd2:    e.operandB = {ins[21:0], 10'b0};
            2'd1:    e.operandB = {{19{ins[12]}}, ins[12:0]};
            default: e.operandB = refForward(ins[4:0], ex, mem, wb);
        endcase
        e.storeData = refForward(ins[29:25], ex, mem, wb);
        e.dest      = c.call ? regAddr_t'(`CALL_LINK_REG) : ins[29:25];
        return e;
    endfunction

    task automatic reportMismatch(input string name, input logic [127:0] expected,
                                  input logic [127:0] actual);
        $display("CHECK FAILED %s expected %0h got %0h at %0t", name, expected, actual, $time);
        errCount++;
    endtask

    task automatic driveCycle(input word_t ins, input stageFwd_t ex, input stageFwd_t mem,
                              input stageFwd_t wb, input logic load);
        @(posedge Clk);
        instr    <= ins;
        exStage  <= ex;
        memStage <= mem;
        wbStage  <= wb;
        exLoad   <= load;
    endtask

    task automatic randomStage(output stageFwd_t s);
        word_t b;
        word_t v;
        randomBits(3, b);
        randomBits(32, v);
        s = makeStage(b[0], {3'b0, b[2:1]}, v);  // Small dest range for frequent hits
    endtask

    task automatic randomHazardCycle(input logic withLoad);
        word_t     b;
        word_t     pad;
        stageFwd_t ex;
        stageFwd_t mem;
        stageFwd_t wb;
        randomBits(15, b);
        randomBits(8, pad);
        randomStage(ex);
        randomStage(mem);
        randomStage(wb);
        ex.rfEnable = ex.rfEnable | (withLoad & b[14]);
        driveCycle(formatInstr({1'b1, b[13]}, {3'b0, b[5:4]}, b[11:6], {3'b0, b[1:0]}, b[12],
                               {pad[7:0], 3'b0, b[3:2]}), ex, mem, wb, withLoad & b[14]);
    endtask

    task automatic loadUseCase(input word_t ins, input regAddr_t loadDest, input logic expStall);
        driveCycle(ins, makeStage(1'b1, loadDest, 32'hC0FFEE01), '0, '0, 1'b1);
        @(negedge Clk);
        checkCount++;
        if (stall !== expStall)
            reportMismatch("stall", expStall, stall);
        if (expStall)
        begin
            @(negedge Clk);
            checkCount++;
            if (idEx.ctrl !== '0)
                reportMismatch("idEx.ctrl", 0, idEx.ctrl);  // Bubble expected
        end
    endtask

    task automatic endTest(input string name);
        repeat (2) driveCycle('0, '0, '0, '0, 1'b0);  // Let pending compares finish
        testNum++;
        $display("Test %0d %s: %s, %0d errors", testNum, name,
                 (errCount == testErrStart) ? "PASS" : "FAIL", errCount - testErrStart);
        testErrStart = errCount;
    endtask

    // Stall now, idEx one cycle after its inputs
    always @(negedge Clk)
    begin
        if (expValid)
        begin
            checkCount++;
            if (idEx.ctrl !== expIdEx.ctrl)
                reportMismatch("idEx.ctrl", expIdEx.ctrl, idEx.ctrl);
            if (idEx.operandA !== expIdEx.operandA)
                reportMismatch("idEx.operandA", expIdEx.operandA, idEx.operandA);
            if (idEx.operandB !== expIdEx.operandB)
                reportMismatch("idEx.operandB", expIdEx.operandB, idEx.operandB);
            if (idEx.storeData !== expIdEx.storeData)
                reportMismatch("idEx.storeData", expIdEx.storeData, idEx.storeData);
            if (idEx.dest !== expIdEx.dest)
                reportMismatch("idEx.dest", expIdEx.dest, idEx.dest);
        end
        checkCount++;
        if (stall !== refStall(instr, exStage, exLoad))
            reportMismatch("stall", refStall(instr, exStage, exLoad), stall);
        expIdEx  = rstN ? refIdEx(instr, exStage, memStage, wbStage, exLoad) : '0;
        expValid = 1'b1;
        if (wbStage.rfEnable && wbStage.dest != 0)
            modelRegs[wbStage.dest] = wbStage.value;  // Readable from the next cycle
    end

    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT)
        begin
            $display("Run stopped after %0d cycles without reaching the end", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        word_t ins;
        instr        = '0;
        exStage      = '0;
        memStage     = '0;
        wbStage      = '0;
        exLoad       = 1'b0;
        modelRegs[0] = '0;
        wait (rstN === 1'b1);
        @(negedge Clk);
        checkCount++;
        if (idEx !== '0)
            reportMismatch("idEx", 0, idEx);
        if (stall !== 1'b0)
            reportMismatch("stall", 0, stall);
        endTest("reset");

        for (int r = 0; r < `NUM_REGS; r++)
            driveCycle('0, '0, '0, makeStage(1'b1, r[4:0], 32'h9E3779B9 * (r + 1)), 1'b0);
        for (int r = 0; r < `NUM_REGS; r++)
            driveCycle(formatInstr(2'b10, r[4:0], 6'd0, r[4:0], 1'b0, 13'(31 - r)),
                       '0, '0, '0, 1'b0);
        endTest("register writes");

        driveCycle(32'h4000_0123, '0, '0, '0, 1'b0);  // Call with rd field 0
        driveCycle({2'b00, 5'd7, 3'b100, 22'h2ABCDE}, '0, '0, '0, 1'b0);
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            randomBits(32, ins);
            driveCycle(ins, '0, '0, '0, 1'b0);
        end
        endTest("random decode");

        for (int n = 0; n < NUM_FWD; n++)
            randomHazardCycle(1'b0);
        endTest("forwarding");

        loadUseCase(formatInstr(2'b10, 5'd3, 6'd0, 5'd5, 1'b0, 13'd9), 5'd5, 1'b1);
        loadUseCase(formatInstr(2'b10, 5'd3, 6'd2, 5'd9, 1'b0, 13'd5), 5'd5, 1'b1);
        loadUseCase(formatInstr(2'b10, 5'd3, 6'd0, 5'd9, 1'b1, 13'd5), 5'd5, 1'b0);
        loadUseCase(formatInstr(2'b10, 5'd3, 6'd0, 5'd0, 1'b0, 13'd0), 5'd0, 1'b0);
        loadUseCase(formatInstr(2'b11, 5'd5, 6'd4, 5'd9, 1'b0, 13'd10), 5'd5, 1'b0);
        loadUseCase({2'b00, 5'd4, 3'b100, 22'h000005}, 5'd5, 1'b0);  // SETHI has no rs2
        for (int n = 0; n < NUM_LOADS; n++)
            randomHazardCycle(1'b1);
        endTest("load-use stall");

        $display("Summary: %0d tests, %0d checks, %0d errors", testNum, checkCount, errCount);
        if (errCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== idStage.f ====
+incdir+source
source/idStagePkg.sv
source/controlDecoder.sv
source/registerFile.sv
source/hazardUnit.sv
source/operandSelect.sv
source/idStage.sv
test/clockGen.sv
test/idStageTb.sv
